//--- verilog/udp_echo_settings.svh
`ifndef UDP_ECHO_SETTINGS_SVH
`define UDP_ECHO_SETTINGS_SVH

// Destination port answered with an echo
`define UDP_ECHO_PORT 16'd1234

// Payload buffer entries, power of two
`define PAYLOAD_FIFO_DEPTH 16

`endif

//--- verilog/udp_echo_pkg.sv
package udp_echo_pkg;

    typedef logic [31:0] ipv4_addr_t;

    typedef logic [15:0] udp_port_t;

    // Length field as carried in the UDP header
    typedef logic [15:0] udp_len_t;

    typedef logic [7:0] payload_byte_t;

    // Received header, and reply header with ip as destination
    typedef struct packed {
        ipv4_addr_t ip;
        udp_port_t  src_port;
        udp_port_t  dst_port;
        udp_len_t   length;
    } udp_meta_t;

endpackage

//--- verilog/udp_echo_ifs.sv
// Header handshake between filter and reply builder
interface hdr_if;
    import udp_echo_pkg::*;

    logic      valid;
    logic      ready;
    udp_meta_t meta;

    modport source (
        output valid,
        output meta,
        input  ready
    );

    modport sink (
        input  valid,
        input  meta,
        output ready
    );
endinterface

// Byte stream, last marks the end of a frame
interface byte_stream_if;
    import udp_echo_pkg::*;

    payload_byte_t data;
    logic          valid;
    logic          ready;
    logic          last;
    logic          user;

    modport source (
        output data,
        output valid,
        output last,
        output user,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready
    );
endinterface

//--- verilog/udp_port_filter.sv
`include "udp_echo_settings.svh"

module udp_port_filter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_hdr_valid,
    output logic                        in_hdr_ready,
    input  udp_echo_pkg::udp_meta_t     in_hdr_meta,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  udp_echo_pkg::payload_byte_t in_data,
    input  logic                        in_last,
    input  logic                        in_user,
    hdr_if.source                       hdr,
    byte_stream_if.source               payload
);
    typedef enum logic [1:0] {
        s_idle,
        s_pass,
        s_drop
    } state_t;

    state_t state;
    logic   live;
    logic   match;
    logic   hdr_fire;
    logic   byte_fire;

    assign match = (in_hdr_meta.dst_port == `UDP_ECHO_PORT);

    // Header side only listens in idle
    assign in_hdr_ready = live && (state == s_idle) && (!match || hdr.ready);
    assign hdr_fire     = in_hdr_valid && in_hdr_ready;

    assign hdr.valid = live && (state == s_idle) && in_hdr_valid && match;
    assign hdr.meta  = in_hdr_meta;

    // Dropped frames are swallowed at full rate
    always_comb begin
        case (state)
            s_pass:  in_ready = payload.ready;
            s_drop:  in_ready = 1'b1;
            default: in_ready = 1'b0;
        endcase
    end

    assign byte_fire = in_valid && in_ready;

    assign payload.valid = (state == s_pass) && in_valid;
    assign payload.data  = in_data;
    assign payload.last  = in_last;
    assign payload.user  = in_user;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
            live  <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                s_idle: begin
                    if (hdr_fire) begin
                        state <= match ? s_pass : s_drop;
                    end
                end
                s_pass, s_drop: begin
                    if (byte_fire && in_last) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/udp_payload_fifo.sv
module udp_payload_fifo #(
    parameter int DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.sink   wr,
    byte_stream_if.source rd
);
    import udp_echo_pkg::*;

    localparam int AW = $clog2(DEPTH);
    // Data plus last and user
    localparam int EW = $bits(payload_byte_t) + 2;
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    logic [EW-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_fire;
    logic          rd_fire;
    logic [EW-1:0] rd_entry;

    assign wr.ready = (count != FULL_COUNT);
    assign rd.valid = (count != '0);

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    assign rd_entry = mem[rd_ptr];
    assign rd.data  = rd_entry[EW-3:0];
    assign rd.last  = rd_entry[EW-2];
    assign rd.user  = rd_entry[EW-1];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr.user, wr.last, wr.data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- verilog/udp_reply_tx.sv
module udp_reply_tx (
    input  logic                        clk,
    input  logic                        rst,
    hdr_if.sink                         hdr,
    byte_stream_if.sink                 payload,
    output logic                        out_hdr_valid,
    input  logic                        out_hdr_ready,
    output udp_echo_pkg::udp_meta_t     out_meta,
    output logic                        out_valid,
    input  logic                        out_ready,
    output udp_echo_pkg::payload_byte_t out_data,
    output logic                        out_last,
    output logic                        out_user,
    output udp_echo_pkg::payload_byte_t first_byte
);
    import udp_echo_pkg::*;

    udp_meta_t     meta_q;
    logic          hdr_full;
    logic          in_sof;
    payload_byte_t first_q;

    // Register takes a new header when empty or draining
    assign hdr.ready = !hdr_full || out_hdr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
        end else if (hdr.valid && hdr.ready) begin
            hdr_full <= 1'b1;
        end else if (out_hdr_ready) begin
            hdr_full <= 1'b0;
        end
    end

    // Reply goes back to the sender with ports swapped
    always_ff @(posedge clk) begin
        if (hdr.valid && hdr.ready) begin
            meta_q.ip       <= hdr.meta.ip;
            meta_q.src_port <= hdr.meta.dst_port;
            meta_q.dst_port <= hdr.meta.src_port;
            meta_q.length   <= hdr.meta.length;
        end
    end

    assign out_hdr_valid = hdr_full;
    assign out_meta      = meta_q;

    assign out_valid     = payload.valid;
    assign out_data      = payload.data;
    assign out_last      = payload.last;
    assign out_user      = payload.user;
    assign payload.ready = out_ready;

    // Keep first byte of each frame for status
    always_ff @(posedge clk) begin
        if (rst) begin
            in_sof  <= 1'b1;
            first_q <= '0;
        end else if (payload.valid && out_ready) begin
            if (in_sof) begin
                first_q <= payload.data;
            end
            in_sof <= payload.last;
        end
    end

    assign first_byte = first_q;

endmodule

//--- verilog/udp_echo_top.sv
`include "udp_echo_settings.svh"

module udp_echo_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_hdr_valid,
    output logic                        in_hdr_ready,
    input  udp_echo_pkg::ipv4_addr_t    in_src_ip,
    input  udp_echo_pkg::udp_port_t     in_src_port,
    input  udp_echo_pkg::udp_port_t     in_dst_port,
    input  udp_echo_pkg::udp_len_t      in_length,
    input  udp_echo_pkg::payload_byte_t in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        in_last,
    input  logic                        in_user,
    output logic                        out_hdr_valid,
    input  logic                        out_hdr_ready,
    output udp_echo_pkg::ipv4_addr_t    out_dst_ip,
    output udp_echo_pkg::udp_port_t     out_src_port,
    output udp_echo_pkg::udp_port_t     out_dst_port,
    output udp_echo_pkg::udp_len_t      out_length,
    output udp_echo_pkg::payload_byte_t out_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic                        out_last,
    output logic                        out_user,
    output udp_echo_pkg::payload_byte_t first_byte
);
    import udp_echo_pkg::*;

    udp_meta_t in_meta;
    udp_meta_t out_meta;

    hdr_if         hdr_link ();
    byte_stream_if filt_bytes ();
    byte_stream_if fifo_bytes ();

    assign in_meta.ip       = in_src_ip;
    assign in_meta.src_port = in_src_port;
    assign in_meta.dst_port = in_dst_port;
    assign in_meta.length   = in_length;

    // ip field of the reply is its destination
    assign out_dst_ip   = out_meta.ip;
    assign out_src_port = out_meta.src_port;
    assign out_dst_port = out_meta.dst_port;
    assign out_length   = out_meta.length;

    udp_port_filter filter_inst (
        .clk          (clk),
        .rst          (rst),
        .in_hdr_valid (in_hdr_valid),
        .in_hdr_ready (in_hdr_ready),
        .in_hdr_meta  (in_meta),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .in_last      (in_last),
        .in_user      (in_user),
        .hdr          (hdr_link.source),
        .payload      (filt_bytes.source)
    );

    udp_payload_fifo #(
        .DEPTH (`PAYLOAD_FIFO_DEPTH)
    ) fifo_inst (
        .clk (clk),
        .rst (rst),
        .wr  (filt_bytes.sink),
        .rd  (fifo_bytes.source)
    );

    udp_reply_tx reply_inst (
        .clk           (clk),
        .rst           (rst),
        .hdr           (hdr_link.sink),
        .payload       (fifo_bytes.sink),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_meta      (out_meta),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_user      (out_user),
        .first_byte    (first_byte)
    );

endmodule

//--- tests/tb_udp_echo.sv
`include "udp_echo_settings.svh"

module tb_udp_echo;
    import udp_echo_pkg::*;

    localparam int WAIT_LIMIT = 2000;
    localparam int MAX_ECHO   = 64;

    logic          clk;
    logic          rst;
    logic          in_hdr_valid;
    logic          in_hdr_ready;
    ipv4_addr_t    in_src_ip;
    udp_port_t     in_src_port;
    udp_port_t     in_dst_port;
    udp_len_t      in_length;
    payload_byte_t in_data;
    logic          in_valid;
    logic          in_ready;
    logic          in_last;
    logic          in_user;
    logic          out_hdr_valid;
    logic          out_hdr_ready;
    ipv4_addr_t    out_dst_ip;
    udp_port_t     out_src_port;
    udp_port_t     out_dst_port;
    udp_len_t      out_length;
    payload_byte_t out_data;
    logic          out_valid;
    logic          out_ready;
    logic          out_last;
    logic          out_user;
    payload_byte_t first_byte;

    // Replies still owed by the DUT
    udp_meta_t     exp_meta[$];
    payload_byte_t exp_data[$];
    // Per byte {last, user}
    logic [1:0]    exp_flags[$];

    string echo_name[MAX_ECHO];
    int    echo_errs[MAX_ECHO];
    int    echo_sent;
    int    errors;
    int    tests;
    int    failed;
    bit    timed_out;
    string cur_name;
    int    remaining;

    udp_echo_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic count_error(input int k);
        errors++;
        if (k >= 0) begin
            echo_errs[k]++;
        end
    endtask

    task automatic check_meta(input string name, input int k, input udp_meta_t exp,
                              input udp_meta_t act);
        if (act !== exp) begin
            $display("mismatch %s header: expected %h actual %h", name, exp, act);
            count_error(k);
        end
    endtask

    task automatic check_byte(input string name, input int k, input payload_byte_t exp,
                              input logic [1:0] exp_lu, input payload_byte_t act,
                              input logic [1:0] act_lu);
        if ({act_lu, act} !== {exp_lu, exp}) begin
            $display("mismatch %s byte: expected %h last/user %b actual %h last/user %b",
                     name, exp, exp_lu, act, act_lu);
            count_error(k);
        end
    endtask

    task automatic check_first(input string name, input int k, input payload_byte_t exp,
                               input payload_byte_t act);
        if (act !== exp) begin
            $display("mismatch %s first_byte: expected %h actual %h", name, exp, act);
            count_error(k);
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests++;
        if (errs == 0) begin
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, errs);
        end
    endtask

    // Hold the driven transfer until the DUT takes it
    task automatic wait_accept(input bit is_hdr, input string what);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            done = is_hdr ? in_hdr_ready : in_ready;
            n++;
        end
        @(negedge clk);
        in_hdr_valid = 1'b0;
        in_valid = 1'b0;
        if (!done) begin
            $display("timeout: %s %s was never accepted", cur_name, what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin : stimulus
        int            fd;
        int            n;
        int            sport;
        int            dport;
        int            len;
        int            count;
        int            user;
        int            drop_base;
        int            longest;
        bit            echo;
        logic [31:0]   ip;
        payload_byte_t first;
        string         line;
        string         kw;
        udp_meta_t     m;

        errors = 0;
        tests = 0;
        failed = 0;
        echo_sent = 0;
        timed_out = 1'b0;
        remaining = 0;
        echo = 1'b0;
        drop_base = 0;
        longest = 0;
        rst = 1'b1;
        in_hdr_valid = 1'b0;
        in_src_ip = '0;
        in_src_port = '0;
        in_dst_port = '0;
        in_length = '0;
        in_data = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("reset", "in_hdr_ready", 1'b0, in_hdr_ready);
        check_flag("reset", "in_ready", 1'b0, in_ready);
        rst = 1'b0;
        @(negedge clk);
        check_flag("reset", "out_hdr_valid", 1'b0, out_hdr_valid);
        check_flag("reset", "out_valid", 1'b0, out_valid);
        check_first("reset", -1, 8'h00, first_byte);
        report_test("reset", errors);

        fd = $fopen("tests/udp_echo_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open tests/udp_echo_testdata.txt");
            errors++;
        end
        while (fd != 0 && !timed_out && !$feof(fd)) begin
            line = "";
            kw = "";
            void'($fgets(line, fd));
            void'($sscanf(line, "%s", kw));
            if (kw == "frame") begin
                void'($sscanf(line, "%s %s %h %d %d %d %d", kw, cur_name, ip, sport, dport,
                              len, count));
                if (remaining != 0 || count == 0 || echo_sent == MAX_ECHO) begin
                    $display("error: bad frame line in test data at %s", cur_name);
                    errors++;
                end
                m.ip = ip;
                m.src_port = 16'(sport);
                m.dst_port = 16'(dport);
                m.length = 16'(len);
                echo = (m.dst_port == `UDP_ECHO_PORT);
                if (echo) begin
                    echo_name[echo_sent] = cur_name;
                    echo_errs[echo_sent] = 0;
                    echo_sent++;
                    if (count > longest) begin
                        longest = count;
                    end
                    // Reply goes back to the sender with the ports swapped
                    exp_meta.push_back({m.ip, m.dst_port, m.src_port, m.length});
                end
                drop_base = errors;
                remaining = count;
                in_hdr_valid = 1'b1;
                in_src_ip = m.ip;
                in_src_port = m.src_port;
                in_dst_port = m.dst_port;
                in_length = m.length;
                wait_accept(1'b1, "header");
            end else if (kw == "bytes") begin
                void'($sscanf(line, "%s %h %d %d", kw, first, count, user));
                for (int i = 0; i < count && !timed_out; i++) begin
                    remaining--;
                    if (echo) begin
                        exp_data.push_back(first + 8'(i));
                        exp_flags.push_back({remaining == 0, user[0]});
                    end
                    in_valid = 1'b1;
                    in_data = first + 8'(i);
                    in_last = (remaining == 0);
                    in_user = user[0];
                    wait_accept(1'b0, "payload byte");
                end
                if (!echo && remaining == 0) begin
                    report_test(cur_name, errors - drop_base);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (fd != 0 && longest <= `PAYLOAD_FIFO_DEPTH) begin
            $display("error: no echoed frame in the test data is longer than the payload FIFO");
            errors++;
        end

        n = 0;
        while (!timed_out && exp_meta.size() + exp_data.size() != 0 && n < WAIT_LIMIT * 4) begin
            @(negedge clk);
            n++;
        end
        if (exp_meta.size() + exp_data.size() != 0) begin
            $display("timeout: %0d reply headers and %0d payload bytes never came out",
                     exp_meta.size(), exp_data.size());
            errors++;
        end
        repeat (2) @(negedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : monitor
        logic [31:0]   rng;
        int            hdr_k;
        int            byte_k;
        int            first_k;
        int            rep_k;
        bit            sof;
        bit            first_due;
        payload_byte_t first_exp;
        payload_byte_t d;
        logic [1:0]    lu;

        rng = 32'h306dc9c8;
        hdr_k = 0;
        byte_k = 0;
        first_k = 0;
        rep_k = 0;
        sof = 1'b1;
        first_due = 1'b0;
        first_exp = '0;
        out_ready = 1'b0;
        out_hdr_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (first_due) begin
                check_first(echo_name[first_k], first_k, first_exp, first_byte);
                first_due = 1'b0;
            end
            // An echo test is done once its header and its last byte are out
            if (rep_k < hdr_k && rep_k < byte_k) begin
                report_test(echo_name[rep_k], echo_errs[rep_k]);
                rep_k++;
            end
            // Bytes drain at about half rate so long frames fill the FIFO
            rng = xorshift(rng);
            out_ready = (rng[2:0] < 3'd4);
            out_hdr_ready = rng[4];
            @(posedge clk);
            if (!rst && out_hdr_valid === 1'b1 && out_hdr_ready) begin
                if (exp_meta.size() == 0) begin
                    $display("error: reply header came out with no echo frame pending");
                    errors++;
                end else begin
                    check_meta(echo_name[hdr_k], hdr_k, exp_meta.pop_front(),
                               {out_dst_ip, out_src_port, out_dst_port, out_length});
                    hdr_k++;
                end
            end
            if (!rst && out_valid === 1'b1 && out_ready) begin
                if (exp_data.size() == 0) begin
                    $display("error: payload byte came out with no echo frame pending");
                    errors++;
                end else begin
                    d = exp_data.pop_front();
                    lu = exp_flags.pop_front();
                    check_byte(echo_name[byte_k], byte_k, d, lu, out_data, {out_last, out_user});
                    if (sof) begin
                        first_due = 1'b1;
                        first_k = byte_k;
                        first_exp = d;
                    end
                    sof = lu[1];
                    if (lu[1]) begin
                        byte_k++;
                    end
                end
            end
        end
    end

endmodule

//--- tests/udp_echo_testdata.txt
# frame: name src_ip(hex) src_port dst_port length payload_bytes
# bytes: first_value(hex) count user, values count up from first_value
frame echo_short c0a80a05 5000 1234 12 4
bytes 11 3 0
bytes a5 1 1
frame drop_other_port c0a80a06 5001 80 14 6
bytes 20 6 0
frame echo_after_drop 0a000001 40000 1234 10 2
bytes 5a 1 1
bytes 5b 1 0
frame echo_single 0a000002 123 1234 9 1
bytes ff 1 0
frame drop_src_port_match 0a0000ff 1234 7 11 3
bytes 33 3 0
frame echo_long_a ac100001 6000 1234 48 40
bytes 00 20 0
bytes 80 20 1
frame drop_near_port ac100002 6001 1235 38 30
bytes 40 30 1
frame echo_long_b ac100003 6002 1234 33 25
bytes 10 25 0
frame echo_long_c c0a80001 53 1234 60 52
bytes f0 26 1
bytes c0 26 0
frame echo_back_to_back 7f000001 65535 1234 11 3
bytes e0 2 0
bytes e2 1 1
frame echo_port_zero 01020304 0 1234 10 2
bytes 00 2 1

//--- src.f
+incdir+verilog
verilog/udp_echo_pkg.sv
verilog/udp_echo_ifs.sv
verilog/udp_port_filter.sv
verilog/udp_payload_fifo.sv
verilog/udp_reply_tx.sv
verilog/udp_echo_top.sv
tests/tb_udp_echo.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_udp_echo
RTL_TOP   ?= udp_echo_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o $(TB_TOP)

run: build
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
